//--- hw/wh_conc_pkg.sv
// ###########################################################################
// wormhole concentrator shared types
// flit, length and channel id widths, the header overlay and the link bundle
// ###########################################################################

package wh_conc_pkg;

  localparam int FLIT_W = 16;
  localparam int LEN_W  = 4;
  localparam int CID_W  = 2;

  // one flit on any link
  typedef logic [FLIT_W-1:0] flit_t;

  // number of payload flits after the header
  typedef logic [LEN_W-1:0] len_t;

  // channel id selecting the unconcentrated link
  typedef logic [CID_W-1:0] cid_t;

  // header view of a flit, len sits in the lowest bits
  typedef struct packed {
    logic [FLIT_W-LEN_W-CID_W-1:0] pad;
    cid_t                          cid;
    len_t                          len;
  } hdr_s;

  // one direction of a link
  // v and data come from this side's sender, ready_rev is this side's receive-ready
  typedef struct packed {
    logic  v;
    flit_t data;
    logic  ready_rev;
  } link_s;

endpackage

//--- hw/wh_two_fifo.sv
// ###########################################################################
// two-entry flit buffer
// registered not-full ready on the input, valid/yumi on the output side
// ###########################################################################

`timescale 1ns/1ps

module wh_two_fifo
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               v_i,
  input  wh_conc_pkg::flit_t data_i,
  output logic               ready_o,
  output logic               v_o,
  output wh_conc_pkg::flit_t data_o,
  input  logic               yumi_i
);

  wh_conc_pkg::flit_t mem_r [2];
  logic [1:0]         wr_ptr_r;
  logic [1:0]         rd_ptr_r;
  logic               full_r;
  logic               empty_r;
  logic               enq;

  // ready comes straight from a flop, no path back from the consumer
  assign ready_o = ~full_r;
  assign enq     = v_i & ~full_r;

  assign v_o    = ~empty_r;
  assign data_o = rd_ptr_r[1] ? mem_r[1] : mem_r[0];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= 2'b01;
      rd_ptr_r <= 2'b01;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= {wr_ptr_r[0], wr_ptr_r[1]};
      if (yumi_i)
        rd_ptr_r <= {rd_ptr_r[0], rd_ptr_r[1]};
      // occupancy only moves when exactly one side acts
      if (enq && !yumi_i)
      begin
        empty_r <= 1'b0;
        full_r  <= ~empty_r;
      end
      else if (yumi_i && !enq)
      begin
        full_r  <= 1'b0;
        empty_r <= ~full_r;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int k = 0; k < 2; k++)
    begin
      if (enq && wr_ptr_r[k])
        mem_r[k] <= data_i;
    end
  end

endmodule

//--- hw/wh_input_ctrl.sv
// ###########################################################################
// wormhole input packet tracker
// follows header and payload count, requests a destination, flags last flit
// ###########################################################################

`timescale 1ns/1ps

module wh_input_ctrl
#(
  parameter int dests_p = 1
)
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               fifo_v_i,
  input  logic               fifo_yumi_i,
  input  logic [dests_p-1:0] dest_i,
  input  wh_conc_pkg::len_t  len_i,
  output logic [dests_p-1:0] reqs_o,
  output logic               release_o
);

  logic               hdr_exp_r;
  wh_conc_pkg::len_t  cnt_r;
  logic [dests_p-1:0] dest_r;
  logic [dests_p-1:0] dest_cur;
  logic               last_flit;

  // on the header the decode is live, afterwards the latched copy steers
  assign dest_cur = hdr_exp_r ? dest_i : dest_r;
  assign reqs_o   = fifo_v_i ? dest_cur : '0;

  // header-only packet ends on its header
  assign last_flit = hdr_exp_r ? (len_i == '0) : (cnt_r == wh_conc_pkg::len_t'(1));
  assign release_o = fifo_v_i & last_flit;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      hdr_exp_r <= 1'b1;
      cnt_r     <= '0;
      dest_r    <= '0;
    end
    else if (fifo_yumi_i)
    begin
      if (hdr_exp_r)
      begin
        cnt_r  <= len_i;
        dest_r <= dest_i;
        if (len_i != '0)
          hdr_exp_r <= 1'b0;
      end
      else
      begin
        cnt_r <= cnt_r - 1'b1;
        if (last_flit)
          hdr_exp_r <= 1'b1;
      end
    end
  end

endmodule

//--- hw/wh_output_arb.sv
// ###########################################################################
// wormhole output arbiter
// round-robin pick, grant held for a whole packet, one-hot flit select
// ###########################################################################

`timescale 1ns/1ps

module wh_output_arb
#(
  parameter int num_in_p = 4
)
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [num_in_p-1:0]                 reqs_i,
  input  logic [num_in_p-1:0]                 release_i,
  input  logic [num_in_p-1:0]                 valid_i,
  input  wh_conc_pkg::flit_t [num_in_p-1:0]   data_i,
  output logic [num_in_p-1:0]                 yumi_o,
  input  logic                                ready_i,
  output logic                                valid_o,
  output wh_conc_pkg::flit_t                  data_o
);

  localparam int idx_w_lp = (num_in_p > 1) ? $clog2(num_in_p) : 1;

  logic [idx_w_lp-1:0] prio_r;
  logic                locked_r;
  logic [num_in_p-1:0] grant_r;
  logic [num_in_p-1:0] pick;
  logic [num_in_p-1:0] sel;
  logic [idx_w_lp-1:0] sel_idx;
  logic                found;
  logic                xfer;
  logic                last_flit;
  int                  cand;

  // first requester at or after the priority pointer
  always_comb
  begin
    pick  = '0;
    found = 1'b0;
    for (int off = 0; off < num_in_p; off++)
    begin
      cand = int'(prio_r) + off;
      if (cand >= num_in_p)
        cand = cand - num_in_p;
      if (!found && reqs_i[cand])
      begin
        pick[cand] = 1'b1;
        found      = 1'b1;
      end
    end
  end

  assign sel = locked_r ? grant_r : pick;

  always_comb
  begin
    sel_idx = '0;
    data_o  = '0;
    for (int i = 0; i < num_in_p; i++)
    begin
      if (sel[i])
      begin
        sel_idx = idx_w_lp'(i);
        data_o  = data_o | data_i[i];
      end
    end
  end

  assign valid_o   = |(sel & valid_i);
  assign xfer      = valid_o & ready_i;
  assign yumi_o    = sel & {num_in_p{xfer}};
  assign last_flit = |(sel & release_i);

  // lock as soon as a flit is offered so v and data stay put under back-pressure
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      prio_r   <= '0;
      locked_r <= 1'b0;
      grant_r  <= '0;
    end
    else if (valid_o)
    begin
      if (xfer && last_flit)
      begin
        locked_r <= 1'b0;
        grant_r  <= '0;
        prio_r   <= (sel_idx == idx_w_lp'(num_in_p - 1)) ? '0 : sel_idx + 1'b1;
      end
      else
      begin
        locked_r <= 1'b1;
        grant_r  <= sel;
      end
    end
  end

endmodule

//--- hw/wh_merge_path.sv
// ###########################################################################
// merge direction
// per-input buffer and tracker lanes joined by one round-robin arbiter
// ###########################################################################

`timescale 1ns/1ps

module wh_merge_path
#(
  parameter int num_in_p = 4
)
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  wh_conc_pkg::link_s [num_in_p-1:0]   links_i,
  output wh_conc_pkg::link_s [num_in_p-1:0]   links_o,
  input  logic                                conc_ready_i,
  output logic                                conc_v_o,
  output wh_conc_pkg::flit_t                  conc_data_o
);

  logic [num_in_p-1:0]               fifo_v;
  wh_conc_pkg::flit_t [num_in_p-1:0] fifo_data;
  logic [num_in_p-1:0]               reqs;
  logic [num_in_p-1:0]               releases;
  logic [num_in_p-1:0]               yumis;

  for (genvar i = 0; i < num_in_p; i++)
  begin : lane
    wh_conc_pkg::hdr_s hdr;

    wh_two_fifo u_fifo
    (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (links_i[i].v),
      .data_i  (links_i[i].data),
      .ready_o (links_o[i].ready_rev),
      .v_o     (fifo_v[i]),
      .data_o  (fifo_data[i]),
      .yumi_i  (yumis[i])
    );

    assign hdr = fifo_data[i];

    // only one way out of a lane, so the destination is always bit 0
    wh_input_ctrl #(.dests_p(1)) u_ctrl
    (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .fifo_v_i    (fifo_v[i]),
      .fifo_yumi_i (yumis[i]),
      .dest_i      (1'b1),
      .len_i       (hdr.len),
      .reqs_o      (reqs[i]),
      .release_o   (releases[i])
    );

    // the return direction of these links belongs to the split path
    assign links_o[i].v    = 1'b0;
    assign links_o[i].data = '0;
  end

  wh_output_arb #(.num_in_p(num_in_p)) u_arb
  (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .reqs_i    (reqs),
    .release_i (releases),
    .valid_i   (fifo_v),
    .data_i    (fifo_data),
    .yumi_o    (yumis),
    .ready_i   (conc_ready_i),
    .valid_o   (conc_v_o),
    .data_o    (conc_data_o)
  );

endmodule

//--- hw/wh_split_path.sv
// ###########################################################################
// split direction
// buffers the concentrated link and steers each packet to its cid output
// ###########################################################################

`timescale 1ns/1ps

module wh_split_path
#(
  parameter int num_in_p = 4
)
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                conc_v_i,
  input  wh_conc_pkg::flit_t  conc_data_i,
  output logic                conc_ready_o,
  input  logic [num_in_p-1:0] out_ready_i,
  output logic [num_in_p-1:0] out_v_o,
  output wh_conc_pkg::flit_t  out_data_o
);

  logic                fifo_v;
  wh_conc_pkg::flit_t  fifo_data;
  wh_conc_pkg::hdr_s   hdr;
  logic [num_in_p-1:0] dest_dec;
  logic [num_in_p-1:0] reqs;
  logic                yumi;

  wh_two_fifo u_fifo
  (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .v_i     (conc_v_i),
    .data_i  (conc_data_i),
    .ready_o (conc_ready_o),
    .v_o     (fifo_v),
    .data_o  (fifo_data),
    .yumi_i  (yumi)
  );

  assign hdr = fifo_data;

  // cid to one-hot, only meaningful while the front flit is a header
  always_comb
  begin
    for (int k = 0; k < num_in_p; k++)
    begin
      dest_dec[k] = (hdr.cid == wh_conc_pkg::cid_t'(k));
    end
  end

  // the tracker remembers the destination for the payload flits
  wh_input_ctrl #(.dests_p(num_in_p)) u_ctrl
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .fifo_v_i    (fifo_v),
    .fifo_yumi_i (yumi),
    .dest_i      (dest_dec),
    .len_i       (hdr.len),
    .reqs_o      (reqs),
    .release_o   ()
  );

  assign out_v_o    = reqs;
  assign out_data_o = fifo_data;

  // a busy destination stalls everything behind it
  assign yumi = |(reqs & out_ready_i);

endmodule

//--- hw/wh_concentrator.sv
// ###########################################################################
// wormhole concentrator top
// N unconcentrated links merged onto one link and split back out
// ###########################################################################

`timescale 1ns/1ps

module wh_concentrator
#(
  parameter int num_in_p = 4
)
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  wh_conc_pkg::link_s [num_in_p-1:0] links_i,
  output wh_conc_pkg::link_s [num_in_p-1:0] links_o,
  input  wh_conc_pkg::link_s                conc_link_i,
  output wh_conc_pkg::link_s                conc_link_o
);

  wh_conc_pkg::link_s [num_in_p-1:0] merge_links;
  logic [num_in_p-1:0]               split_ready;
  logic [num_in_p-1:0]               split_v;
  wh_conc_pkg::flit_t                split_data;

  wh_merge_path #(.num_in_p(num_in_p)) u_merge
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .links_i      (links_i),
    .links_o      (merge_links),
    .conc_ready_i (conc_link_i.ready_rev),
    .conc_v_o     (conc_link_o.v),
    .conc_data_o  (conc_link_o.data)
  );

  wh_split_path #(.num_in_p(num_in_p)) u_split
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .conc_v_i     (conc_link_i.v),
    .conc_data_i  (conc_link_i.data),
    .conc_ready_o (conc_link_o.ready_rev),
    .out_ready_i  (split_ready),
    .out_v_o      (split_v),
    .out_data_o   (split_data)
  );

  // merge owns the ready back to each link, split owns the forward flits
  for (genvar i = 0; i < num_in_p; i++)
  begin : link_map
    assign split_ready[i]       = links_i[i].ready_rev;
    assign links_o[i].v         = split_v[i];
    assign links_o[i].data      = split_data;
    assign links_o[i].ready_rev = merge_links[i].ready_rev;
  end

endmodule

//--- testbench/wh_checker.sv
// ###########################################################################
// concentrator checker
// expected-flit queues per direction and channel, compared on every transfer
// ###########################################################################

`timescale 1ns/1ps

module wh_checker
#(
  parameter int num_in_p = 4
)
(
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              fair_en_i,
  input wh_conc_pkg::link_s [num_in_p-1:0] links_i,
  input wh_conc_pkg::link_s [num_in_p-1:0] links_o,
  input wh_conc_pkg::link_s                conc_link_i,
  input wh_conc_pkg::link_s                conc_link_o
);

  // queue index is dir * num_in_p + channel with dir 0 for merge and dir 1 for split
  wh_conc_pkg::flit_t exp_q [2*num_in_p][$];
  int                 err_cnt = 0;
  int                 merge_rem = 0;
  int                 merge_ch = 0;
  // packets from other inputs since this input's last one, counted from test start
  int                 since [num_in_p];

  task automatic expect_flit(input int dir, input int ch, input wh_conc_pkg::flit_t f);
    exp_q[dir*num_in_p+ch].push_back(f);
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int q = 0; q < 2*num_in_p; q++)
      n = n + exp_q[q].size();
    return n;
  endfunction

  task automatic report_missing();
    for (int q = 0; q < 2*num_in_p; q++)
    begin
      if (exp_q[q].size() > 0)
        $display("%0d flits never arrived on %s channel %0d", exp_q[q].size(),
                 (q < num_in_p) ? "merge" : "split", q % num_in_p);
    end
  endtask

  task automatic check_idle();
    if (conc_link_o.v !== 1'b0 || conc_link_o.ready_rev !== 1'b1)
    begin
      err_cnt++;
      $display("concentrated link not idle after reset");
    end
    for (int k = 0; k < num_in_p; k++)
    begin
      if (links_o[k].v !== 1'b0 || links_o[k].ready_rev !== 1'b1)
      begin
        err_cnt++;
        $display("link %0d not idle after reset", k);
      end
    end
  endtask

  task automatic compare_flit(input int q, input string name, input wh_conc_pkg::flit_t got);
    wh_conc_pkg::flit_t exp;
    if (exp_q[q].size() == 0)
    begin
      err_cnt++;
      $display("unexpected flit %h on %s with nothing outstanding", got, name);
    end
    else
    begin
      exp = exp_q[q].pop_front();
      if (exp !== got)
      begin
        err_cnt++;
        $display("Fail %s expected %h got %h", name, exp, got);
      end
    end
  endtask

  task automatic observe_merge(input wh_conc_pkg::flit_t f);
    wh_conc_pkg::hdr_s h;
    int ch;
    h = f;
    if (merge_rem == 0)
    begin
      ch        = int'(h.cid);
      merge_ch  = ch;
      merge_rem = int'(h.len);
      if (fair_en_i && since[ch] > num_in_p - 1)
      begin
        err_cnt++;
        $display("input %0d waited behind %0d other packets", ch, since[ch]);
      end
      for (int j = 0; j < num_in_p; j++)
        since[j]++;
      since[ch] = 0;
    end
    else
      merge_rem--;
    compare_flit(merge_ch, "conc_link_o.data", f);
  endtask

  // values settle 1 ns after the rising edge, so the falling edge sees them stable
  always @(negedge clk_i)
  begin
    if (!fair_en_i)
    begin
      for (int j = 0; j < num_in_p; j++)
        since[j] = 0;
    end
    if (rst_n_i)
    begin
      if (conc_link_o.v && conc_link_i.ready_rev)
        observe_merge(conc_link_o.data);
      for (int k = 0; k < num_in_p; k++)
      begin
        if (links_o[k].v && links_i[k].ready_rev)
          compare_flit(num_in_p + k, $sformatf("links_o[%0d].data", k), links_o[k].data);
      end
    end
  end

endmodule

//--- testbench/wh_concentrator_sva.sv
// ###########################################################################
// concentrator assertions
// output link stability under back-pressure, reset state, one split output
// ###########################################################################

`timescale 1ns/1ps

module wh_concentrator_sva
#(
  parameter int num_in_p = 4
)
(
  input logic                              clk_i,
  input logic                              rst_n_i,
  input wh_conc_pkg::link_s [num_in_p-1:0] links_i,
  input wh_conc_pkg::link_s [num_in_p-1:0] links_o,
  input wh_conc_pkg::link_s                conc_link_i,
  input wh_conc_pkg::link_s                conc_link_o
);

  logic [num_in_p-1:0] split_v;

  for (genvar k = 0; k < num_in_p; k++)
  begin : out_chk
    assign split_v[k] = links_o[k].v;

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      links_o[k].v && !links_i[k].ready_rev |=> links_o[k].v && $stable(links_o[k].data))
      else $error("split output %0d changed before acceptance", k);
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    conc_link_o.v && !conc_link_i.ready_rev |=> conc_link_o.v && $stable(conc_link_o.data))
    else $error("concentrated output changed before acceptance");

  assert property (@(posedge clk_i) $rose(rst_n_i) |-> !conc_link_o.v && split_v == '0)
    else $error("output valid high right after reset");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(split_v))
    else $error("more than one split output valid");

endmodule

bind wh_concentrator wh_concentrator_sva #(.num_in_p(num_in_p)) u_sva
(
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .links_i     (links_i),
  .links_o     (links_o),
  .conc_link_i (conc_link_i),
  .conc_link_o (conc_link_o)
);

//--- testbench/tb_wh_concentrator.sv
// ###########################################################################
// wormhole concentrator testbench
// random packet sources and sinks on both directions, per-test report
// ###########################################################################

`timescale 1ns/1ps

module tb_wh_concentrator;

  localparam int num_in_lp     = 4;
  localparam int total_pkts_lp = 180;
  // every packet has at most 16 flits
  localparam int limit_lp      = total_pkts_lp * 16 * 8 + 200;

  logic                                clk_i;
  logic                                rst_n_i;
  wh_conc_pkg::link_s [num_in_lp-1:0]  links_in;
  wh_conc_pkg::link_s [num_in_lp-1:0]  links_out;
  wh_conc_pkg::link_s                  conc_in;
  wh_conc_pkg::link_s                  conc_out;
  logic                                fair_en;

  // sources 0..3 feed the merge inputs, source 4 feeds the concentrated input
  wh_conc_pkg::flit_t src_q [num_in_lp+1][$];
  int                 seq_cnt [num_in_lp+1];
  logic [31:0]        rnd_state;
  logic               bp_en;
  logic               gap_en;
  int                 cycles;
  int                 pass_cnt;
  int                 fail_cnt;

  wh_concentrator #(.num_in_p(num_in_lp)) UUT
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .links_i     (links_in),
    .links_o     (links_out),
    .conc_link_i (conc_in),
    .conc_link_o (conc_out)
  );

  wh_checker #(.num_in_p(num_in_lp)) u_chk
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .fair_en_i   (fair_en),
    .links_i     (links_in),
    .links_o     (links_out),
    .conc_link_i (conc_in),
    .conc_link_o (conc_out)
  );

  function automatic logic [31:0] next_rand();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 17);
    rnd_state = rnd_state ^ (rnd_state << 5);
    return rnd_state;
  endfunction

  // expected flit from source, sequence number and position in the packet
  function automatic wh_conc_pkg::flit_t ref_flit(input int src, input int seq,
                                                  input int idx, input int len,
                                                  input int cid);
    wh_conc_pkg::hdr_s h;
    if (idx == 0)
    begin
      h.pad = seq[9:0];
      h.cid = wh_conc_pkg::cid_t'(cid);
      h.len = wh_conc_pkg::len_t'(len);
      return h;
    end
    return {src[2:0], seq[4:0], idx[7:0]};
  endfunction

  task automatic queue_packet(input int src, input int dir, input int cid,
                              input bit zero_mix);
    int len;
    int seq;
    wh_conc_pkg::flit_t f;
    len = int'(next_rand() % 16);
    if (zero_mix && (next_rand() % 2 == 1))
      len = 0;
    seq = seq_cnt[src];
    seq_cnt[src]++;
    for (int idx = 0; idx <= len; idx++)
    begin
      f = ref_flit(src, seq, idx, len, cid);
      src_q[src].push_back(f);
      u_chk.expect_flit(dir, cid, f);
    end
  endtask

  task automatic run_test(input string name, input int merge_n, input int split_n,
                          input bit bp, input bit gap, input bit fair, input bit zero_mix);
    int err_before;
    int busy;
    err_before = u_chk.err_cnt;
    bp_en      = bp;
    gap_en     = gap;
    fair_en    = fair;
    for (int n = 0; n < merge_n; n++)
    begin
      for (int i = 0; i < num_in_lp; i++)
        queue_packet(i, 0, i, zero_mix);
    end
    for (int n = 0; n < split_n; n++)
      queue_packet(num_in_lp, 1, int'(next_rand() % num_in_lp), zero_mix);
    busy = 1;
    while (busy != 0)
    begin
      @(negedge clk_i);
      busy = u_chk.pending();
      for (int s = 0; s <= num_in_lp; s++)
        busy = busy + src_q[s].size();
    end
    fair_en = 1'b0;
    if (u_chk.err_cnt == err_before)
    begin
      pass_cnt++;
      $display("test %s: passed", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, u_chk.err_cnt - err_before);
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever
      #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > limit_lp)
    begin
      u_chk.report_missing();
      $display("timeout after %0d cycles, traffic did not drain", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // sources hold v and data until accepted, sinks toggle ready at random
  initial
  begin : drive_loop
    logic acc [num_in_lp+1];
    logic v_now;
    forever
    begin
      @(negedge clk_i);
      for (int s = 0; s < num_in_lp; s++)
        acc[s] = links_in[s].v & links_out[s].ready_rev;
      acc[num_in_lp] = conc_in.v & conc_out.ready_rev;
      @(posedge clk_i);
      #1;
      for (int s = 0; s <= num_in_lp; s++)
      begin
        v_now = (s < num_in_lp) ? links_in[s].v : conc_in.v;
        if (acc[s])
          void'(src_q[s].pop_front());
        if (!(v_now && !acc[s]))
        begin
          v_now = (src_q[s].size() > 0) && !(gap_en && (next_rand() % 4 == 0));
          if (s < num_in_lp)
          begin
            links_in[s].v    = v_now;
            links_in[s].data = v_now ? src_q[s][0] : '0;
          end
          else
          begin
            conc_in.v    = v_now;
            conc_in.data = v_now ? src_q[s][0] : '0;
          end
        end
      end
      for (int k = 0; k < num_in_lp; k++)
        links_in[k].ready_rev = bp_en ? ((next_rand() & 32'h8) != 0) : 1'b1;
      conc_in.ready_rev = bp_en ? ((next_rand() & 32'h8) != 0) : 1'b1;
    end
  end

  initial
  begin
    rnd_state = 32'h3051;
    rst_n_i   = 1'b0;
    links_in  = '0;
    conc_in   = '0;
    fair_en   = 1'b0;
    bp_en     = 1'b0;
    gap_en    = 1'b0;
    cycles    = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    for (int s = 0; s <= num_in_lp; s++)
      seq_cnt[s] = 0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    for (int k = 0; k < num_in_lp; k++)
      links_in[k].ready_rev = 1'b1;
    conc_in.ready_rev = 1'b1;
    repeat (3) @(negedge clk_i);
    begin : reset_test
      int err_before;
      err_before = u_chk.err_cnt;
      u_chk.check_idle();
      if (u_chk.err_cnt == err_before)
      begin
        pass_cnt++;
        $display("test reset_state: passed");
      end
      else
      begin
        fail_cnt++;
        $display("test reset_state: failed");
      end
    end
    run_test("merge", 8, 0, 1'b0, 1'b1, 1'b0, 1'b0);
    run_test("split", 0, 24, 1'b0, 1'b1, 1'b0, 1'b0);
    run_test("merge_backpressure", 8, 0, 1'b1, 1'b1, 1'b0, 1'b0);
    run_test("split_backpressure", 0, 24, 1'b1, 1'b1, 1'b0, 1'b0);
    run_test("fairness", 6, 0, 1'b0, 1'b0, 1'b1, 1'b0);
    run_test("header_only_duplex", 6, 20, 1'b1, 1'b1, 1'b0, 1'b1);
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- compile.f
hw/wh_conc_pkg.sv
hw/wh_two_fifo.sv
hw/wh_input_ctrl.sv
hw/wh_output_arb.sv
hw/wh_merge_path.sv
hw/wh_split_path.sv
hw/wh_concentrator.sv
testbench/wh_checker.sv
testbench/wh_concentrator_sva.sv
testbench/tb_wh_concentrator.sv

//--- run.sh
#!/bin/bash
# build and run the concentrator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_wh_concentrator -o sim_wh_concentrator \
  && out="$(./obj_dir/sim_wh_concentrator)" \
  && echo "$out" \
  && echo "$out" | grep -q "Everything OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
